// ==== rf_defs.svh ====
// Register file dimensions
// Word, address and byte-parity widths shared by the package and the RTL

`ifndef RF_DEFS_SVH
`define RF_DEFS_SVH

//////////////////////////////
// Register file geometry
//////////////////////////////

// Architectural registers, x0 included
`define RF_NUM_REGS 32

// Register index width
`define RF_ADDR_W 5

// Register value width
`define RF_DATA_W 32

//////////////////////////////
// Integrity code
//////////////////////////////

// One even-parity bit covers this many data bits
`define RF_BYTE_W 8

// Parity bits per word, data width over byte width
`define RF_INTG_W 4

`endif

// ==== rf_pkg.sv ====
// Register file types
// Core busy state encoding

`include "rf_defs.svh"

package rf_pkg;

  // Register index
  typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

  // Register value
  typedef logic [`RF_DATA_W-1:0] rf_data_t;

  // Even parity per byte, bit i covers byte i
  typedef logic [`RF_INTG_W-1:0] rf_intg_t;

  // Core activity seen by the main clock gate
  typedef enum logic {
    CoreIdle = 1'b0,
    CoreBusy = 1'b1
  } core_state_e;

endpackage

// ==== core_clock_gate.sv ====
// Main clock gate of the core
// Busy state register, wake condition, latch gate and sleep indication

`timescale 1ns/10ps

module core_clock_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic clk_gated_o,
  output logic core_sleep_o
);
  import rf_pkg::*;

  core_state_e busy_q;
  logic        clock_en;
  logic        en_latched;

  // Busy flag from the core sampled every cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= CoreIdle;
    end else begin
      busy_q <= core_busy_i ? CoreBusy : CoreIdle;
    end
  end

  // Any wake source keeps the core clock running
  assign clock_en     = (busy_q == CoreBusy) | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  //////////////////////////////
  // Glitch-free gate
  //////////////////////////////

  // Enable only moves while clk_i is low
  always_latch begin
    if (!clk_i) begin
      en_latched = clock_en | test_en_i;
    end
  end

  assign clk_gated_o = clk_i & en_latched;

  // NMI must always wake the core
  a_nmi_wakes: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_nm_i |-> !core_sleep_o);

endmodule

// ==== reg_file_ff.sv ====
// Flip-flop register file, two read ports and one write port
// Each word stores its parity bits, x0 is hard-wired to zero

`timescale 1ns/10ps

`include "rf_defs.svh"

module reg_file_ff (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  rf_pkg::rf_addr_t raddr_a_i,
  input  rf_pkg::rf_addr_t raddr_b_i,
  input  rf_pkg::rf_addr_t waddr_i,
  input  rf_pkg::rf_data_t wdata_i,
  input  rf_pkg::rf_intg_t wintg_i,
  input  logic             we_i,
  output rf_pkg::rf_data_t rdata_a_o,
  output rf_pkg::rf_data_t rdata_b_o,
  output rf_pkg::rf_intg_t rintg_a_o,
  output rf_pkg::rf_intg_t rintg_b_o
);
  import rf_pkg::*;

  logic [`RF_NUM_REGS-1:1] we_dec;
  rf_data_t                data_q   [`RF_NUM_REGS-1:1];
  rf_intg_t                intg_q   [`RF_NUM_REGS-1:1];
  rf_data_t                data_all [`RF_NUM_REGS];
  rf_intg_t                intg_all [`RF_NUM_REGS];

  // Write address decode
  always_comb begin
    for (int i = 1; i < `RF_NUM_REGS; i++) begin
      we_dec[i] = we_i & (waddr_i == rf_addr_t'(i));
    end
  end

  //////////////////////////////
  // Storage
  //////////////////////////////

  for (genvar i = 1; i < `RF_NUM_REGS; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        data_q[i] <= '0;
        intg_q[i] <= '0;
      end else if (we_dec[i]) begin
        data_q[i] <= wdata_i;
        intg_q[i] <= wintg_i;
      end
    end

    assign data_all[i] = data_q[i];
    assign intg_all[i] = intg_q[i];
  end

  // x0, zero data with matching zero parity
  assign data_all[0] = '0;
  assign intg_all[0] = '0;

  //////////////////////////////
  // Read ports
  //////////////////////////////

  assign rdata_a_o = data_all[raddr_a_i];
  assign rintg_a_o = intg_all[raddr_a_i];
  assign rdata_b_o = data_all[raddr_b_i];
  assign rintg_b_o = intg_all[raddr_b_i];

  // x0 reads as an all-zero codeword on both ports
  a_x0_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((raddr_a_i == '0) |-> (rdata_a_o == '0 && rintg_a_o == '0)) and
    ((raddr_b_i == '0) |-> (rdata_b_o == '0 && rintg_b_o == '0)));

endmodule

// ==== rf_intg_check.sv ====
// Register file integrity check
// Byte parity recompute on both read ports, registered major alert

`timescale 1ns/10ps

`include "rf_defs.svh"

module rf_intg_check (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  rf_pkg::rf_data_t rdata_a_i,
  input  rf_pkg::rf_data_t rdata_b_i,
  input  rf_pkg::rf_intg_t rintg_a_i,
  input  rf_pkg::rf_intg_t rintg_b_i,
  output logic             alert_major_o
);
  import rf_pkg::*;

  rf_intg_t calc_a;
  rf_intg_t calc_b;
  logic     err_a;
  logic     err_b;
  logic     alert_q;

  // Even parity over each byte
  always_comb begin
    for (int i = 0; i < `RF_INTG_W; i++) begin
      calc_a[i] = ^rdata_a_i[i*`RF_BYTE_W +: `RF_BYTE_W];
      calc_b[i] = ^rdata_b_i[i*`RF_BYTE_W +: `RF_BYTE_W];
    end
  end

  assign err_a = (calc_a != rintg_a_i);
  assign err_b = (calc_b != rintg_b_i);

  // Alert follows the read by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= err_a | err_b;
    end
  end

  assign alert_major_o = alert_q;

  a_alert_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(alert_major_o));

endmodule

// ==== rf_top.sv ====
// Top level around the core
// Main clock gate, flip-flop register file and its integrity check

`timescale 1ns/10ps

module rf_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             test_en_i,
  input  logic             core_busy_i,
  input  logic             debug_req_i,
  input  logic             irq_pending_i,
  input  logic             irq_nm_i,
  input  rf_pkg::rf_addr_t raddr_a_i,
  input  rf_pkg::rf_addr_t raddr_b_i,
  input  rf_pkg::rf_addr_t waddr_i,
  input  rf_pkg::rf_data_t wdata_i,
  input  rf_pkg::rf_intg_t wintg_i,
  input  logic             we_i,
  output rf_pkg::rf_data_t rdata_a_o,
  output rf_pkg::rf_data_t rdata_b_o,
  output logic             alert_major_o,
  output logic             core_sleep_o
);
  import rf_pkg::*;

  logic     clk_gated;
  rf_intg_t rintg_a;
  rf_intg_t rintg_b;

  //////////////////////////////
  // Main clock gate
  //////////////////////////////

  core_clock_gate u_clock_gate (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .test_en_i     (test_en_i),
    .core_busy_i   (core_busy_i),
    .debug_req_i   (debug_req_i),
    .irq_pending_i (irq_pending_i),
    .irq_nm_i      (irq_nm_i),
    .clk_gated_o   (clk_gated),
    .core_sleep_o  (core_sleep_o)
  );

  //////////////////////////////
  // Register file
  //////////////////////////////

  // Runs on the gated clock, writes are lost while asleep
  reg_file_ff u_reg_file (
    .clk_i     (clk_gated),
    .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a_i),
    .raddr_b_i (raddr_b_i),
    .waddr_i   (waddr_i),
    .wdata_i   (wdata_i),
    .wintg_i   (wintg_i),
    .we_i      (we_i),
    .rdata_a_o (rdata_a_o),
    .rdata_b_o (rdata_b_o),
    .rintg_a_o (rintg_a),
    .rintg_b_o (rintg_b)
  );

  // Checker stays on the free-running clock
  rf_intg_check u_intg_check (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rdata_a_i     (rdata_a_o),
    .rdata_b_i     (rdata_b_o),
    .rintg_a_i     (rintg_a),
    .rintg_b_i     (rintg_b),
    .alert_major_o (alert_major_o)
  );

endmodule

// ==== rf_tb.sv ====
// Testbench for rf_top
// Stimulus table with expectations from a register model, check task and timeout

`timescale 1ns/10ps

`include "rf_defs.svh"

module rf_tb;
  import rf_pkg::*;

  typedef struct packed {
    logic [3:0] test_id;
    rf_addr_t   waddr;
    rf_data_t   wdata;
    logic       bad_par;
    logic       we;
    rf_addr_t   raddr_a;
    rf_addr_t   raddr_b;
    logic       busy;
    logic       dbg;
    logic       irq;
    logic       nmi;
    rf_data_t   exp_a;
    rf_data_t   exp_b;
    logic       exp_alert;
    logic       exp_sleep;
  } entry_t;

  logic     clk_i;
  logic     rst_ni;
  logic     test_en_i;
  logic     core_busy_i;
  logic     debug_req_i;
  logic     irq_pending_i;
  logic     irq_nm_i;
  rf_addr_t raddr_a_i;
  rf_addr_t raddr_b_i;
  rf_addr_t waddr_i;
  rf_data_t wdata_i;
  rf_intg_t wintg_i;
  logic     we_i;
  rf_data_t rdata_a_o;
  rf_data_t rdata_b_o;
  logic     alert_major_o;
  logic     core_sleep_o;

  entry_t      table_q [$];
  rf_data_t    model_data [`RF_NUM_REGS];
  rf_intg_t    model_intg [`RF_NUM_REGS];
  logic        prev_busy;
  logic [31:0] rng_state;
  int          errors = 0;
  int          checks = 0;
  int          tests_done = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  rf_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Run limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: the table did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic rf_data_t next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Even parity, bit i over byte i
  function automatic rf_intg_t byte_parity(input rf_data_t d);
    rf_intg_t p;
    for (int i = 0; i < `RF_INTG_W; i++) begin
      p[i] = ^d[i*`RF_BYTE_W +: `RF_BYTE_W];
    end
    return p;
  endfunction

  // Corruption flips one parity bit picked by the low data bits
  function automatic rf_intg_t write_intg(input rf_data_t d, input logic bad);
    rf_intg_t flip;
    flip = rf_intg_t'(1) << d[1:0];
    return bad ? (byte_parity(d) ^ flip) : byte_parity(d);
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset state";
      2:       return "busy write and read back";
      3:       return "sleep and wake sources";
      4:       return "parity error alert";
      5:       return "parity repair";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic add_entry(input int test_id, input int waddr, input rf_data_t wdata,
                           input logic bad_par, input logic we, input int ra, input int rb,
                           input logic busy, input logic dbg, input logic irq, input logic nmi);
    entry_t e;
    logic   err_a;
    logic   err_b;
    logic   lands;
    e.test_id = 4'(test_id);
    e.waddr   = rf_addr_t'(waddr);
    e.wdata   = wdata;
    e.bad_par = bad_par;
    e.we      = we;
    e.raddr_a = rf_addr_t'(ra);
    e.raddr_b = rf_addr_t'(rb);
    e.busy    = busy;
    e.dbg     = dbg;
    e.irq     = irq;
    e.nmi     = nmi;
    // Alert sees the words stored before this cycle's write
    err_a = (byte_parity(model_data[ra]) != model_intg[ra]);
    err_b = (byte_parity(model_data[rb]) != model_intg[rb]);
    e.exp_alert = err_a | err_b;
    // Clock at the write edge runs on last cycle's busy flag or a wake input
    lands = we && (waddr != 0) && (prev_busy || dbg || irq || nmi);
    if (lands) begin
      model_data[waddr] = wdata;
      model_intg[waddr] = write_intg(wdata, bad_par);
    end
    e.exp_a     = model_data[ra];
    e.exp_b     = model_data[rb];
    e.exp_sleep = !(busy || dbg || irq || nmi);
    prev_busy   = busy;
    table_q.push_back(e);
  endtask

  task automatic add_read(input int test_id, input int ra, input int rb,
                          input logic busy, input logic dbg, input logic irq, input logic nmi);
    add_entry(test_id, 0, '0, 1'b0, 1'b0, ra, rb, busy, dbg, irq, nmi);
  endtask

  task automatic build_table();
    int r;
    for (int k = 0; k < `RF_NUM_REGS; k += 2) begin
      add_read(1, k, k + 1, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    add_read(2, 0, 0, 1'b1, 1'b0, 1'b0, 1'b0);
    for (int k = 1; k < `RF_NUM_REGS; k++) begin
      add_entry(2, k, next_random(), 1'b0, 1'b1, k, k, 1'b1, 1'b0, 1'b0, 1'b0);
    end
    add_entry(2, 0, next_random(), 1'b0, 1'b1, 0, 0, 1'b1, 1'b0, 1'b0, 1'b0);
    add_read(2, 0, `RF_NUM_REGS - 1, 1'b1, 1'b0, 1'b0, 1'b0);
    // One lost write, then one woken write, per wake source
    add_read(3, 3, 4, 1'b0, 1'b0, 1'b0, 1'b0);
    for (int w = 0; w < 3; w++) begin
      add_entry(3, 3 + w, next_random(), 1'b0, 1'b1, 3 + w, 3 + w,
                1'b0, 1'b0, 1'b0, 1'b0);
      add_entry(3, 3 + w, next_random(), 1'b0, 1'b1, 3 + w, 3 + w,
                1'b0, w == 0, w == 1, w == 2);
    end
    add_read(3, 3, 4, 1'b0, 1'b0, 1'b0, 1'b0);
    add_read(3, 5, 0, 1'b0, 1'b0, 1'b0, 1'b0);
    add_read(4, 0, 0, 1'b1, 1'b0, 1'b0, 1'b0);
    for (int k = 0; k < 3; k++) begin
      r = 7 + 6 * k;
      add_entry(4, r, next_random(), 1'b1, 1'b1, 0, 0, 1'b1, 1'b0, 1'b0, 1'b0);
      add_read(4, r, 0, 1'b1, 1'b0, 1'b0, 1'b0);
      add_read(4, 1, 1, 1'b1, 1'b0, 1'b0, 1'b0);
      add_read(4, 0, r, 1'b1, 1'b0, 1'b0, 1'b0);
    end
    for (int k = 0; k < 3; k++) begin
      r = 7 + 6 * k;
      add_entry(5, r, next_random(), 1'b0, 1'b1, 0, 0, 1'b1, 1'b0, 1'b0, 1'b0);
      add_read(5, r, r, 1'b1, 1'b0, 1'b0, 1'b0);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    entry_t e;
    int     group_err;
    rng_state = 32'hfc6a4aa9;
    prev_busy = 1'b0;
    for (int k = 0; k < `RF_NUM_REGS; k++) begin
      model_data[k] = '0;
      model_intg[k] = '0;
    end
    build_table();
    cycle_limit = 8 * table_q.size() + 100;

    rst_ni        = 1'b0;
    test_en_i     = 1'b0;
    core_busy_i   = 1'b0;
    debug_req_i   = 1'b0;
    irq_pending_i = 1'b0;
    irq_nm_i      = 1'b0;
    raddr_a_i     = '0;
    raddr_b_i     = '0;
    waddr_i       = '0;
    wdata_i       = '0;
    wintg_i       = '0;
    we_i          = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    group_err = 0;
    for (int i = 0; i < table_q.size(); i++) begin
      e = table_q[i];
      core_busy_i   = e.busy;
      debug_req_i   = e.dbg;
      irq_pending_i = e.irq;
      irq_nm_i      = e.nmi;
      waddr_i       = e.waddr;
      wdata_i       = e.wdata;
      wintg_i       = write_intg(e.wdata, e.bad_par);
      we_i          = e.we;
      raddr_a_i     = e.raddr_a;
      raddr_b_i     = e.raddr_b;
      // Outputs have settled half a cycle after the edge
      @(negedge clk_i);
      check_value(rdata_a_o, e.exp_a, $sformatf("entry %0d rdata_a", i));
      check_value(rdata_b_o, e.exp_b, $sformatf("entry %0d rdata_b", i));
      check_value(32'(alert_major_o), 32'(e.exp_alert), $sformatf("entry %0d alert", i));
      check_value(32'(core_sleep_o), 32'(e.exp_sleep), $sformatf("entry %0d sleep", i));
      if (i == table_q.size() - 1 || table_q[i + 1].test_id != e.test_id) begin
        tests_done++;
        if (errors == group_err) begin
          $display("Test %0d (%s): ok", e.test_id, test_name(int'(e.test_id)));
        end else begin
          $display("Test %0d (%s): %0d errors", e.test_id, test_name(int'(e.test_id)),
                   errors - group_err);
        end
        group_err = errors;
      end
    end

    $display("Tests: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+.
rf_pkg.sv
core_clock_gate.sv
reg_file_ff.sv
rf_intg_check.sv
rf_top.sv
rf_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       := rf_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
